// ==== vlog.f ====
mem_pkg.sv
dp_ram_bank.sv
bank_select.sv
read_return.sv
mem_subsys_top.sv
tb_clk_gen.sv
mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module mem_subsys_tb -o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/mem_subsys_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test passed$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// ==== mem_subsys_tb.sv ====
// Memory subsystem testbench with random traffic checked against a byte-array model
module mem_subsys_tb
  import mem_pkg::*;
;

  localparam int          DRV_DLY   = 1;         // Drive and sample offset after the edge
  localparam int          RST_LIMIT = 100;       // Cycles allowed for reset release
  localparam int unsigned SEED      = 32'h2a44;  // Fixed stimulus seed
  localparam int          MEM_BYTES = 1 << ADDR_W;

  logic  clk;
  logic  arst_n;
  logic  en_a;
  addr_t addr_a;
  logic  en_b;
  strb_t be_b;
  addr_t addr_b;
  word_t wdata_b;
  word_t rdata_a;
  word_t rdata_b;

  logic [BYTE_W-1:0] ref_mem [MEM_BYTES];  // Reference storage with one entry per byte address
  word_t exp_a;                            // Expected port A output
  word_t exp_b;                            // Expected port B output
  int    err_cnt;
  int    chk_cnt;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_subsys_top mem_subsys_top_inst (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .en_a_i    (en_a),
    .addr_a_i  (addr_a),
    .en_b_i    (en_b),
    .be_b_i    (be_b),
    .addr_b_i  (addr_b),
    .wdata_b_i (wdata_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  // Model word at a byte address with the offset bits dropped
  function automatic word_t read_ref_word(input addr_t addr);
    word_t w;
    int    base;
    base = int'(addr) & ~(NUM_BYTES - 1);
    for (int i = 0; i < NUM_BYTES; i++) begin
      w[i*BYTE_W +: BYTE_W] = ref_mem[base + i];
    end
    return w;
  endfunction

  task automatic write_ref_bytes(input addr_t addr, input strb_t be, input word_t wd);
    int base;
    base = int'(addr) & ~(NUM_BYTES - 1);
    for (int i = 0; i < NUM_BYTES; i++) begin
      if (be[i]) begin
        ref_mem[base + i] = wd[i*BYTE_W +: BYTE_W];  // Unstrobed bytes untouched
      end
    end
  endtask

  task automatic check_word(input string what, input word_t act, input word_t exp);
    chk_cnt++;
    if (act !== exp) begin
      $display("FAILED %0t: %s got %h expected %h", $time, what, act, exp);
      err_cnt++;
    end
  endtask

  // Drives one clock of traffic on both ports and compares both outputs with the model
  task automatic access_cycle(input logic ea, input addr_t aa, input logic eb,
                              input strb_t bb, input addr_t ab, input word_t wd);
    en_a    = ea;
    addr_a  = aa;
    en_b    = eb;
    be_b    = bb;
    addr_b  = ab;
    wdata_b = wd;
    if (ea) begin
      exp_a = read_ref_word(aa);  // Taken before the model write for read before write
    end
    if (eb && bb == '0) begin
      exp_b = read_ref_word(ab);
    end else if (eb) begin
      write_ref_bytes(ab, bb, wd);
    end
    @(posedge clk);
    #DRV_DLY;
    check_word("port A read data", rdata_a, exp_a);
    check_word("port B read data", rdata_b, exp_b);
  endtask

  task automatic wait_reset_release(output logic released);
    int cnt;
    cnt = 0;
    while (arst_n !== 1'b1 && cnt < RST_LIMIT) begin
      @(posedge clk);
      cnt++;
    end
    released = (arst_n === 1'b1);
    if (released) begin
      #DRV_DLY;
    end else begin
      $display("Timeout: reset was not released within %0d cycles", RST_LIMIT);
    end
  endtask

  task automatic run_test_phases();
    logic [31:0] rnd;
    logic [31:0] rnd2;
    addr_t       aa;
    addr_t       ab;
    word_t       wd;
    word_t       wd_old;
    strb_t       bb;
    word_t       hold_a;
    word_t       hold_b;
    check_word("port A after reset", rdata_a, '0);
    check_word("port B after reset", rdata_b, '0);

    // Never-written memory reads back as zero
    for (int n = 0; n < 16; n++) begin
      rnd = $urandom;
      access_cycle(1'b1, rnd[ADDR_W-1:0], 1'b1, '0, rnd[31:32-ADDR_W], '0);
    end

    // Full word write and readback on A and on B
    for (int n = 0; n < 8; n++) begin
      rnd = $urandom;
      wd  = $urandom;
      ab  = rnd[ADDR_W-1:0];
      access_cycle(1'b0, '0, 1'b1, 4'hF, ab, wd);
      access_cycle(1'b1, ab, 1'b0, '0, '0, '0);
      check_word("port A readback", rdata_a, wd);
      access_cycle(1'b0, '0, 1'b1, '0, ab, '0);
      check_word("port B readback", rdata_b, wd);
    end

    // Partial strobes into four words with varied offset bits
    for (int n = 0; n < 48; n++) begin
      rnd = $urandom;
      wd  = $urandom;
      bb  = rnd[7:4];
      if (bb == '0) begin
        bb = 4'h1;  // Keep it a write
      end
      ab = {8'h5a, rnd[3:0]};
      aa = {8'h5a, rnd[3:2], rnd[9:8]};
      access_cycle(1'b0, '0, 1'b1, bb, ab, wd);
      access_cycle(1'b1, aa, 1'b1, '0, {ab[ADDR_W-1:OFFS_W], rnd[11:10]}, '0);
    end

    // Random traffic on both ports over the whole range
    for (int n = 0; n < 2000; n++) begin
      rnd  = $urandom;
      rnd2 = $urandom;
      wd   = $urandom;
      bb   = rnd[2] ? strb_t'(0) : rnd[7:4];  // About half of port B accesses read
      access_cycle(rnd[0], rnd2[ADDR_W-1:0], rnd[1], bb, rnd2[31:32-ADDR_W], wd);
    end

    // Port A reads the word that port B writes in the same cycle
    for (int n = 0; n < 16; n++) begin
      rnd    = $urandom;
      wd_old = $urandom;
      wd     = $urandom;
      ab     = rnd[ADDR_W-1:0];
      aa     = {ab[ADDR_W-1:OFFS_W], rnd[21:20]};
      access_cycle(1'b0, '0, 1'b1, 4'hF, ab, wd_old);
      access_cycle(1'b1, aa, 1'b1, 4'hF, ab, wd);
      check_word("collision returns old word", rdata_a, wd_old);
      access_cycle(1'b1, aa, 1'b0, '0, '0, '0);
      check_word("read after collision", rdata_a, wd);
    end

    // Outputs hold across idle cycles and port B writes
    access_cycle(1'b1, aa, 1'b1, '0, ab, '0);  // Word just written, so nonzero data
    hold_a = exp_a;
    hold_b = exp_b;
    for (int n = 0; n < 6; n++) begin
      access_cycle(1'b0, '0, 1'b0, '0, '0, '0);
    end
    for (int n = 0; n < 6; n++) begin
      rnd = $urandom;
      wd  = $urandom;
      access_cycle(1'b0, '0, 1'b1, 4'hF, rnd[ADDR_W-1:0], wd);
    end
    check_word("port A hold", rdata_a, hold_a);
    check_word("port B hold across writes", rdata_b, hold_b);
  endtask

  initial begin
    logic rst_ok;
    en_a    = 1'b0;
    addr_a  = '0;
    en_b    = 1'b0;
    be_b    = '0;
    addr_b  = '0;
    wdata_b = '0;
    exp_a   = '0;
    exp_b   = '0;
    err_cnt = 0;
    chk_cnt = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = '0;
    end
    void'($urandom(SEED));  // Seeds the generator for the whole run
    wait_reset_release(rst_ok);
    if (rst_ok) begin
      run_test_phases();
    end else begin
      err_cnt++;
    end

    $display("Summary: %0d errors in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset generator, 10 unit period with reset held for 8 cycles
module tb_clk_gen (
  output logic clk_o,    // Free-running clock
  output logic arst_n_o  // Active-low reset, released after the reset cycles
);

  localparam int HALF_PERIOD = 5;  // Half of the 10 unit period
  localparam int RST_CYCLES  = 8;  // Rising edges with reset asserted

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;                  // Asserted from time 0
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 arst_n_o = 1'b1;               // Release just after an edge
  end

endmodule

// ==== mem_subsys_top.sv ====
// Dual-port memory subsystem with four word-interleaved banks behind one shared address space
module mem_subsys_top
  import mem_pkg::*;
(
  input  logic  clk_i,      // Clock
  input  logic  arst_n_i,   // Async reset, active low
  input  logic  en_a_i,     // Instruction port enable
  input  addr_t addr_a_i,   // Instruction port byte address
  input  logic  en_b_i,     // Data port enable
  input  strb_t be_b_i,     // Data port byte strobes
  input  addr_t addr_b_i,   // Data port byte address
  input  word_t wdata_b_i,  // Data port write data
  output word_t rdata_a_o,  // Instruction port read data
  output word_t rdata_b_o   // Data port read data
);

  bank_vec_t  bank_en_a;                 // Per-bank port A enables
  bank_vec_t  bank_en_b;                 // Per-bank port B enables
  bank_addr_t loc_addr_a;                // Port A word index, shared by all banks
  bank_addr_t loc_addr_b;                // Port B word index, shared by all banks
  bank_idx_t  sel_a;                     // Port A bank number
  bank_idx_t  sel_b;                     // Port B bank number
  logic       rd_a;                      // Port A read pulse
  logic       rd_b;                      // Port B read pulse
  word_t      bank_rdata_a [NUM_BANKS];  // Port A data per bank
  word_t      bank_rdata_b [NUM_BANKS];  // Port B data per bank

  bank_select bank_select_inst (
    .en_a_i       (en_a_i),
    .addr_a_i     (addr_a_i),
    .en_b_i       (en_b_i),
    .be_b_i       (be_b_i),
    .addr_b_i     (addr_b_i),
    .bank_en_a_o  (bank_en_a),
    .bank_en_b_o  (bank_en_b),
    .loc_addr_a_o (loc_addr_a),
    .loc_addr_b_o (loc_addr_b),
    .sel_a_o      (sel_a),
    .sel_b_o      (sel_b),
    .rd_a_o       (rd_a),
    .rd_b_o       (rd_b)
  );

  // Strobes and write data fan out unchanged, the enable picks the bank
  for (genvar gi = 0; gi < NUM_BANKS; gi++) begin : g_bank
    dp_ram_bank dp_ram_bank_inst (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .en_a_i    (bank_en_a[gi]),
      .addr_a_i  (loc_addr_a),
      .en_b_i    (bank_en_b[gi]),
      .be_b_i    (be_b_i),
      .addr_b_i  (loc_addr_b),
      .wdata_b_i (wdata_b_i),
      .rdata_a_o (bank_rdata_a[gi]),
      .rdata_b_o (bank_rdata_b[gi])
    );
  end

  read_return read_return_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .rd_a_i         (rd_a),
    .rd_b_i         (rd_b),
    .sel_a_i        (sel_a),
    .sel_b_i        (sel_b),
    .bank_rdata_a_i (bank_rdata_a),
    .bank_rdata_b_i (bank_rdata_b),
    .rdata_a_o      (rdata_a_o),
    .rdata_b_o      (rdata_b_o)
  );

endmodule

// ==== read_return.sv ====
// Read-return stage that remembers the bank each port read and steers its data out
module read_return
  import mem_pkg::*;
(
  input  logic      clk_i,                       // Clock
  input  logic      arst_n_i,                    // Async reset, active low
  input  logic      rd_a_i,                      // Port A read pulse
  input  logic      rd_b_i,                      // Port B read pulse
  input  bank_idx_t sel_a_i,                     // Port A bank number
  input  bank_idx_t sel_b_i,                     // Port B bank number
  input  word_t     bank_rdata_a_i [NUM_BANKS],  // Port A data from every bank
  input  word_t     bank_rdata_b_i [NUM_BANKS],  // Port B data from every bank
  output word_t     rdata_a_o,                   // Port A read data
  output word_t     rdata_b_o                    // Port B read data
);

  bank_idx_t sel_a_q;  // Bank that holds the last port A read
  bank_idx_t sel_b_q;  // Bank that holds the last port B read

  // Captured at the same edge the banks capture their data
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_a_q <= '0;
    end else if (rd_a_i) begin
      sel_a_q <= sel_a_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_b_q <= '0;
    end else if (rd_b_i) begin
      sel_b_q <= sel_b_i;  // Writes leave the last read bank in place
    end
  end

  // Output mux; the chosen bank holds its register until its next read,
  // so idle cycles and writes show the previous word
  assign rdata_a_o = bank_rdata_a_i[sel_a_q];
  assign rdata_b_o = bank_rdata_b_i[sel_b_q];

endmodule

// ==== bank_select.sv ====
// Bank selector that splits both byte addresses into bank enables and bank-local word indices
module bank_select
  import mem_pkg::*;
(
  input  logic       en_a_i,        // Port A enable
  input  addr_t      addr_a_i,      // Port A byte address
  input  logic       en_b_i,        // Port B enable
  input  strb_t      be_b_i,        // Port B byte strobes
  input  addr_t      addr_b_i,      // Port B byte address
  output bank_vec_t  bank_en_a_o,   // One-hot port A bank enables
  output bank_vec_t  bank_en_b_o,   // One-hot port B bank enables
  output bank_addr_t loc_addr_a_o,  // Port A word index inside the bank
  output bank_addr_t loc_addr_b_o,  // Port B word index inside the bank
  output bank_idx_t  sel_a_o,       // Port A bank number
  output bank_idx_t  sel_b_o,       // Port B bank number
  output logic       rd_a_o,        // Port A reads this cycle
  output logic       rd_b_o         // Port B reads this cycle
);

  bank_idx_t bank_a;  // Bank number taken from port A address
  bank_idx_t bank_b;  // Bank number taken from port B address

  // Byte offset bits fall away here, which word-aligns every access
  assign bank_a       = addr_a_i[BANK_LSB +: BANK_IDX_W];
  assign bank_b       = addr_b_i[BANK_LSB +: BANK_IDX_W];
  assign loc_addr_a_o = addr_a_i[WORD_LSB +: BANK_ADDR_W];
  assign loc_addr_b_o = addr_b_i[WORD_LSB +: BANK_ADDR_W];

  assign sel_a_o = bank_a;
  assign sel_b_o = bank_b;

  // One-hot decode, only the addressed bank sees an enable
  always_comb begin
    bank_en_a_o = '0;
    bank_en_b_o = '0;
    if (en_a_i) begin
      bank_en_a_o[bank_a] = 1'b1;
    end
    if (en_b_i) begin
      bank_en_b_o[bank_b] = 1'b1;
    end
  end

  // Port A is read-only; port B reads when no strobe is set
  assign rd_a_o = en_a_i;
  assign rd_b_o = en_b_i && (be_b_i == '0);

endmodule

// ==== dp_ram_bank.sv ====
// Single memory bank with a word read port and a byte-strobed read/write port
module dp_ram_bank
  import mem_pkg::*;
(
  input  logic       clk_i,      // Clock
  input  logic       arst_n_i,   // Async reset, active low, output regs only
  input  logic       en_a_i,     // Port A read enable
  input  bank_addr_t addr_a_i,   // Port A word index
  input  logic       en_b_i,     // Port B enable
  input  strb_t      be_b_i,     // Port B byte strobes, zero means read
  input  bank_addr_t addr_b_i,   // Port B word index
  input  word_t      wdata_b_i,  // Port B write data
  output word_t      rdata_a_o,  // Port A read data, 1 cycle latency
  output word_t      rdata_b_o   // Port B read data, 1 cycle latency
);

  // Storage kept as byte lanes so strobed writes touch single bytes
  logic [NUM_BYTES-1:0][BYTE_W-1:0] mem [BANK_WORDS];

  logic we_b;  // Port B write this cycle
  logic re_b;  // Port B read this cycle

  assign we_b = en_b_i && (be_b_i != '0);  // Any strobe set means write
  assign re_b = en_b_i && (be_b_i == '0);  // Enable with no strobe means read

  // Memory powers up cleared, reset leaves contents alone
  initial begin
    for (int w = 0; w < BANK_WORDS; w++) begin
      mem[w] = '0;
    end
  end

  // Byte-strobed write from port B
  always @(posedge clk_i) begin
    if (we_b) begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (be_b_i[i]) begin
          mem[addr_b_i][i] <= wdata_b_i[i*BYTE_W +: BYTE_W];  // Only strobed lanes change
        end
      end
    end
  end

  // Port A output register, samples old word on a same-edge write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_a_o <= '0;
    end else if (en_a_i) begin
      rdata_a_o <= mem[addr_a_i];  // Whole word read
    end
  end

  // Port B output register, holds across its own writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_b_o <= '0;
    end else if (re_b) begin
      rdata_b_o <= mem[addr_b_i];
    end
  end

endmodule

// ==== mem_pkg.sv ====
// Memory subsystem package with the sizes, the byte address split and the data types
package mem_pkg;

  // Data word layout
  localparam int DATA_W    = 32;               // Bits per word
  localparam int BYTE_W    = 8;                // Bits per byte lane
  localparam int NUM_BYTES = DATA_W / BYTE_W;  // Byte lanes per word

  // Bank organization
  localparam int NUM_BANKS   = 4;                   // Word-interleaved banks
  localparam int BANK_WORDS  = 256;                 // Words stored in each bank
  localparam int BANK_IDX_W  = $clog2(NUM_BANKS);   // Bank number width
  localparam int BANK_ADDR_W = $clog2(BANK_WORDS);  // Word index width inside a bank

  // Byte address split, low to high: byte offset, bank number, word in bank
  localparam int OFFS_W   = $clog2(NUM_BYTES);                // Byte offset, ignored
  localparam int BANK_LSB = OFFS_W;                           // First bank number bit
  localparam int WORD_LSB = OFFS_W + BANK_IDX_W;              // First word index bit
  localparam int ADDR_W   = OFFS_W + BANK_IDX_W + BANK_ADDR_W;  // Full byte address

  typedef logic [ADDR_W-1:0]      addr_t;       // Byte address
  typedef logic [DATA_W-1:0]      word_t;       // One data word
  typedef logic [NUM_BYTES-1:0]   strb_t;       // Byte strobes, bit i for byte i
  typedef logic [BANK_IDX_W-1:0]  bank_idx_t;   // Bank number
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;  // Word index inside a bank
  typedef logic [NUM_BANKS-1:0]   bank_vec_t;   // One bit per bank

endpackage
